// File: common/cu_setup_pkg.sv
// All sizes are fixed constants here and FIFO_DEPTH must stay a power of two
`default_nettype none

package cu_setup_pkg;

    // ------------------------------
    // Address and count widths
    // ------------------------------
    localparam int ADDR_W  = 32;
    localparam int COUNT_W = 16;

    // Read word size in bytes, also the address stride
    localparam int WORD_BYTES = 8;

    // ------------------------------
    // Request FIFO sizing
    // ------------------------------
    localparam int FIFO_DEPTH  = 32;
    localparam int PROG_THRESH = 16;
    localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
    // Extra bit so that full and empty differ
    localparam int FIFO_OCC_W  = FIFO_PTR_W + 1;

    // ------------------------------
    // Types
    // ------------------------------
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [COUNT_W-1:0] count_t;

    typedef enum logic [2:0] {
        SETUP_RESET     = 3'd0,
        SETUP_IDLE      = 3'd1,
        SETUP_REQ_START = 3'd2,
        SETUP_REQ_BUSY  = 3'd3,
        SETUP_REQ_PAUSE = 3'd4,
        SETUP_REQ_DONE  = 3'd5
    } setup_state_t;

endpackage

`default_nettype wire

// File: hw/setup_input_regs.sv
// Payload is captured only on an accepted descriptor and holds until the next one
`default_nettype none

module setup_input_regs (
    input  wire                  ap_clk,
    input  wire                  areset_cu_setup,
    input  wire                  descriptor_valid,
    input  wire                  descriptor_ready,
    input  wire cu_setup_pkg::addr_t  descriptor_base,
    input  wire cu_setup_pkg::count_t descriptor_count,
    input  wire                  response_valid,
    output logic                 desc_valid_q,
    output cu_setup_pkg::addr_t  desc_base_q,
    output cu_setup_pkg::count_t desc_count_q,
    output logic                 resp_valid_q
);

    logic desc_accept;

    // Transfer happens only with both sides high
    assign desc_accept = descriptor_valid & descriptor_ready;

    // ------------------------------
    // Valid bits
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            desc_valid_q <= 1'b0;
            resp_valid_q <= 1'b0;
        end else begin
            desc_valid_q <= desc_accept;
            resp_valid_q <= response_valid;
        end
    end

    // ------------------------------
    // Descriptor payload
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (desc_accept) begin
            desc_base_q  <= descriptor_base;
            desc_count_q <= descriptor_count;
        end
    end

endmodule

`default_nettype wire

// File: hw/setup/setup_sequencer.sv
// Expects exactly one resp_valid_q pulse per request issued in the current run
`default_nettype none

module setup_sequencer (
    input  wire                  ap_clk,
    input  wire                  areset_cu_setup,
    input  wire                  desc_valid_q,
    input  wire cu_setup_pkg::addr_t  desc_base_q,
    input  wire cu_setup_pkg::count_t desc_count_q,
    input  wire                  resp_valid_q,
    input  wire                  engine_done,
    input  wire                  fifo_empty,
    input  wire                  fifo_prog_full,
    output logic                 descriptor_ready,
    output logic                 engine_start,
    output cu_setup_pkg::addr_t  engine_base,
    output cu_setup_pkg::count_t engine_count,
    output logic                 issue_enable,
    output logic                 done
);
    import cu_setup_pkg::*;

    setup_state_t state;
    setup_state_t state_next;
    count_t       resp_count;
    logic         resp_zero;
    logic         run_complete;
    logic         waiting;
    logic         accept_q;

    assign resp_zero    = (resp_count == '0);
    assign run_complete = engine_done & fifo_empty & resp_zero;
    assign waiting      = (state == SETUP_IDLE) | (state == SETUP_REQ_DONE);
    // Descriptor taken by the input stage one cycle ago
    assign accept_q     = desc_valid_q & waiting;

    // ------------------------------
    // State machine
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            state <= SETUP_RESET;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            SETUP_RESET: begin
                state_next = SETUP_IDLE;
            end
            SETUP_IDLE, SETUP_REQ_DONE: begin
                if (accept_q) begin
                    state_next = SETUP_REQ_START;
                end
            end
            SETUP_REQ_START: begin
                state_next = SETUP_REQ_BUSY;
            end
            SETUP_REQ_BUSY: begin
                if (run_complete) begin
                    state_next = SETUP_REQ_DONE;
                end else if (fifo_prog_full) begin
                    state_next = SETUP_REQ_PAUSE;
                end
            end
            SETUP_REQ_PAUSE: begin
                if (!fifo_prog_full) begin
                    state_next = SETUP_REQ_BUSY;
                end
            end
            default: begin
                state_next = SETUP_RESET;
            end
        endcase
    end

    // Ready drops right behind an accepted descriptor
    assign descriptor_ready = waiting & ~desc_valid_q;
    assign done             = (state == SETUP_REQ_DONE) & ~desc_valid_q;
    assign engine_start     = (state == SETUP_REQ_START);
    assign issue_enable     = (state == SETUP_REQ_BUSY);

    // Run parameters held for the whole run
    always_ff @(posedge ap_clk) begin
        if (accept_q) begin
            engine_base  <= desc_base_q;
            engine_count <= desc_count_q;
        end
    end

    // ------------------------------
    // Outstanding response counter
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            resp_count <= '0;
        end else if (engine_start) begin
            resp_count <= engine_count;
        end else if (resp_valid_q) begin
            resp_count <= resp_count - 1'b1;
        end
    end

    // Memory side must not return more words than were requested
    a_no_extra_response: assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        (state == SETUP_REQ_BUSY && resp_zero) |-> !resp_valid_q
    ) else $error("response arrived with no request outstanding");

endmodule

`default_nettype wire

// File: hw/setup/serial_read_engine.sv
// Pushes are not flow controlled here and rely on the sequencer pausing issue_enable
`default_nettype none

module serial_read_engine (
    input  wire                  ap_clk,
    input  wire                  areset_cu_setup,
    input  wire                  engine_start,
    input  wire cu_setup_pkg::addr_t  engine_base,
    input  wire cu_setup_pkg::count_t engine_count,
    input  wire                  issue_enable,
    output logic                 push_valid,
    output cu_setup_pkg::addr_t  push_addr,
    output logic                 engine_done
);
    import cu_setup_pkg::*;

    addr_t  next_addr;
    count_t remaining;

    assign engine_done = (remaining == '0);
    assign push_valid  = issue_enable & ~engine_done;
    assign push_addr   = next_addr;

    // ------------------------------
    // Remaining word count
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            remaining <= '0;
        end else if (engine_start) begin
            remaining <= engine_count;
        end else if (push_valid) begin
            remaining <= remaining - 1'b1;
        end
    end

    // ------------------------------
    // Address generator
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (engine_start) begin
            next_addr <= engine_base;
        end else if (push_valid) begin
            next_addr <= next_addr + addr_t'(WORD_BYTES);
        end
    end

    // A new run starts only after the previous one drained
    a_start_when_drained: assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        engine_start |-> engine_done
    ) else $error("engine restarted with words remaining");

endmodule

`default_nettype wire

// File: hw/request_fifo.sv
// Writer must honour fifo_prog_full since push_valid has no full back-pressure
`default_nettype none

module request_fifo (
    input  wire                  ap_clk,
    input  wire                  areset_cu_setup,
    input  wire                  push_valid,
    input  wire cu_setup_pkg::addr_t push_addr,
    input  wire                  request_ready,
    output logic                 request_valid,
    output cu_setup_pkg::addr_t  request_addr,
    output logic                 fifo_empty,
    output logic                 fifo_prog_full
);
    import cu_setup_pkg::*;

    addr_t                 mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_OCC_W-1:0] used;
    logic                  head_free;
    logic                  pop_mem;
    logic                  bypass;
    logic                  write_mem;

    // Head register can take a new entry this cycle
    assign head_free = ~request_valid | request_ready;
    assign pop_mem   = head_free & (used != '0);
    // Empty buffer goes straight to the head
    assign bypass    = head_free & (used == '0) & push_valid;
    assign write_mem = push_valid & ~bypass;

    assign fifo_empty     = (used == '0) & ~request_valid;
    assign fifo_prog_full = (used >= FIFO_OCC_W'(PROG_THRESH));

    // ------------------------------
    // Storage
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (write_mem) begin
            mem[wr_ptr] <= push_addr;
        end
    end

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            used          <= '0;
            request_valid <= 1'b0;
        end else begin
            if (write_mem) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_mem) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            used <= used + FIFO_OCC_W'(write_mem) - FIFO_OCC_W'(pop_mem);
            if (head_free) begin
                request_valid <= pop_mem | bypass;
            end
        end
    end

    // Head payload only moves when the slot is free
    always_ff @(posedge ap_clk) begin
        if (pop_mem) begin
            request_addr <= mem[rd_ptr];
        end else if (bypass) begin
            request_addr <= push_addr;
        end
    end

    a_no_push_when_full: assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        push_valid |-> (used != FIFO_OCC_W'(FIFO_DEPTH))
    ) else $error("push into a full request FIFO");

endmodule

`default_nettype wire

// File: hw/cu_setup_top.sv
// One run at a time and response_valid must pulse once per accepted request
`default_nettype none

module cu_setup_top (
    input  wire                  ap_clk,
    input  wire                  areset_cu_setup,
    input  wire                  descriptor_valid,
    input  wire cu_setup_pkg::addr_t  descriptor_base,
    input  wire cu_setup_pkg::count_t descriptor_count,
    output logic                 descriptor_ready,
    output logic                 request_valid,
    output cu_setup_pkg::addr_t  request_addr,
    input  wire                  request_ready,
    input  wire                  response_valid,
    output logic                 done
);
    import cu_setup_pkg::*;

    // ------------------------------
    // Input stage to sequencer
    // ------------------------------
    logic   desc_valid_q;
    addr_t  desc_base_q;
    count_t desc_count_q;
    logic   resp_valid_q;

    // ------------------------------
    // Sequencer, engine and FIFO
    // ------------------------------
    logic   engine_start;
    addr_t  engine_base;
    count_t engine_count;
    logic   issue_enable;
    logic   engine_done;
    logic   push_valid;
    addr_t  push_addr;
    logic   fifo_empty;
    logic   fifo_prog_full;

    setup_input_regs u_input_regs (
        .ap_clk           (ap_clk),
        .areset_cu_setup  (areset_cu_setup),
        .descriptor_valid (descriptor_valid),
        .descriptor_ready (descriptor_ready),
        .descriptor_base  (descriptor_base),
        .descriptor_count (descriptor_count),
        .response_valid   (response_valid),
        .desc_valid_q     (desc_valid_q),
        .desc_base_q      (desc_base_q),
        .desc_count_q     (desc_count_q),
        .resp_valid_q     (resp_valid_q)
    );

    setup_sequencer u_sequencer (
        .ap_clk           (ap_clk),
        .areset_cu_setup  (areset_cu_setup),
        .desc_valid_q     (desc_valid_q),
        .desc_base_q      (desc_base_q),
        .desc_count_q     (desc_count_q),
        .resp_valid_q     (resp_valid_q),
        .engine_done      (engine_done),
        .fifo_empty       (fifo_empty),
        .fifo_prog_full   (fifo_prog_full),
        .descriptor_ready (descriptor_ready),
        .engine_start     (engine_start),
        .engine_base      (engine_base),
        .engine_count     (engine_count),
        .issue_enable     (issue_enable),
        .done             (done)
    );

    serial_read_engine u_read_engine (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .engine_start    (engine_start),
        .engine_base     (engine_base),
        .engine_count    (engine_count),
        .issue_enable    (issue_enable),
        .push_valid      (push_valid),
        .push_addr       (push_addr),
        .engine_done     (engine_done)
    );

    request_fifo u_request_fifo (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .push_valid      (push_valid),
        .push_addr       (push_addr),
        .request_ready   (request_ready),
        .request_valid   (request_valid),
        .request_addr    (request_addr),
        .fifo_empty      (fifo_empty),
        .fifo_prog_full  (fifo_prog_full)
    );

endmodule

`default_nettype wire

// File: verif/tb_cu_setup.sv
// Self-checking testbench for cu_setup_top with fixed seed stimulus and a simple memory model
`default_nettype none

module tb_cu_setup;
    timeunit 1ns;
    timeprecision 1ps;

    import cu_setup_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int RESET_CYC   = 16;
    localparam int NUM_RUNS    = 24;
    localparam int MAX_COUNT   = 40;
    localparam int WATCHDOG_NS = NUM_RUNS * (MAX_COUNT + 1) * 100 * CLK_PERIOD;
    localparam logic [31:0] SEED = 32'd41120;

    logic   ap_clk = 1'b0;
    logic   areset_cu_setup;
    logic   descriptor_valid;
    addr_t  descriptor_base;
    count_t descriptor_count;
    logic   descriptor_ready;
    logic   request_valid;
    addr_t  request_addr;
    logic   request_ready = 1'b0;
    logic   response_valid = 1'b0;
    logic   done;

    // Independent random streams per process
    logic [31:0] rng_stim  = SEED;
    logic [31:0] rng_ready = SEED ^ 32'h0000_ffff;
    logic [31:0] rng_mem   = SEED ^ 32'hffff_0000;

    int     errors = 0;
    logic   stall_heavy = 1'b0;
    int     stall_left = 0;
    int     resp_delay = 0;
    int     accepted_total = 0;
    int     resp_sent_total = 0;
    int     runs_checked = 0;

    // Current run as seen on the descriptor bus
    logic   run_active = 1'b0;
    addr_t  run_base;
    count_t run_count;
    count_t req_seen;
    count_t resp_seen;

    cu_setup_top DUT (
        .ap_clk           (ap_clk),
        .areset_cu_setup  (areset_cu_setup),
        .descriptor_valid (descriptor_valid),
        .descriptor_base  (descriptor_base),
        .descriptor_count (descriptor_count),
        .descriptor_ready (descriptor_ready),
        .request_valid    (request_valid),
        .request_addr     (request_addr),
        .request_ready    (request_ready),
        .response_valid   (response_valid),
        .done             (done)
    );

    always #(CLK_PERIOD / 2) ap_clk = ~ap_clk;

    // ------------------------------
    // Reference model and compares
    // ------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Word n of a run sits n words above the base
    function automatic addr_t expected_addr(input addr_t base, input count_t index);
        return base + addr_t'(index) * addr_t'(WORD_BYTES);
    endfunction

    task automatic check_addr(input addr_t actual, input addr_t expected, input string what);
        if (actual !== expected) begin
            errors++;
            $display("FAIL @ %0t ns: %s got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic check_count(input count_t actual, input count_t expected, input string what);
        if (actual !== expected) begin
            errors++;
            $display("FAIL @ %0t ns: %s got %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            errors++;
            $display("FAIL @ %0t ns: %s got %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // ------------------------------
    // Bus agents
    // ------------------------------
    task automatic send_descriptor(input addr_t base, input count_t count);
        while (!descriptor_ready) begin
            @(negedge ap_clk);
        end
        descriptor_valid = 1'b1;
        descriptor_base  = base;
        descriptor_count = count;
        @(negedge ap_clk);
        descriptor_valid = 1'b0;
        check_flag(done, 1'b0, "done right after descriptor accept");
    endtask

    task automatic wait_done();
        while (!done) begin
            @(negedge ap_clk);
        end
    endtask

    // Random stalls with long ones on heavy runs
    always @(negedge ap_clk) begin
        if (stall_left != 0) begin
            request_ready = 1'b0;
            stall_left = stall_left - 1;
        end else begin
            request_ready = 1'b1;
            rng_ready = xorshift32(rng_ready);
            if (stall_heavy && rng_ready[3:0] < 4'd4) begin
                stall_left = 16 + int'(rng_ready[13:8]);
            end else if (!stall_heavy && rng_ready[3:0] == 4'd0) begin
                stall_left = int'(rng_ready[10:8]);
            end
        end
    end

    // Memory model with one response pulse per accepted request
    always @(negedge ap_clk) begin
        if (resp_delay != 0) begin
            response_valid = 1'b0;
            resp_delay = resp_delay - 1;
        end else if (accepted_total != resp_sent_total) begin
            response_valid = 1'b1;
            resp_sent_total = resp_sent_total + 1;
            rng_mem = xorshift32(rng_mem);
            resp_delay = int'(rng_mem[2:0]);
        end else begin
            response_valid = 1'b0;
        end
    end

    // ------------------------------
    // Checker
    // ------------------------------
    always @(posedge ap_clk) begin
        if (!areset_cu_setup) begin
            if (request_valid && request_ready) begin
                accepted_total = accepted_total + 1;
                if (!run_active) begin
                    errors++;
                    $display("ERROR: request accepted with no run in progress at %0t ns", $time);
                end else if (req_seen >= run_count) begin
                    errors++;
                    $display("ERROR: more requests than the descriptor count at %0t ns", $time);
                end else begin
                    check_addr(request_addr, expected_addr(run_base, req_seen), "request address");
                end
                req_seen = req_seen + 1'b1;
            end
            if (response_valid) begin
                resp_seen = resp_seen + 1'b1;
            end
            // Done is only legal once every request and response is through
            if (run_active && done) begin
                check_count(req_seen, run_count, "requests at done");
                check_count(resp_seen, run_count, "responses at done");
                run_active = 1'b0;
                runs_checked = runs_checked + 1;
            end
            if (descriptor_valid && descriptor_ready) begin
                run_active = 1'b1;
                run_base   = descriptor_base;
                run_count  = descriptor_count;
                req_seen   = '0;
                resp_seen  = '0;
            end
        end
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int     run;
        int     wait_cycles;
        int     gap;
        count_t count;
        addr_t  base;

        areset_cu_setup  = 1'b1;
        descriptor_valid = 1'b0;
        descriptor_base  = '0;
        descriptor_count = '0;
        repeat (RESET_CYC) @(negedge ap_clk);
        check_flag(descriptor_ready, 1'b0, "descriptor_ready in reset");
        check_flag(request_valid, 1'b0, "request_valid in reset");
        check_flag(done, 1'b0, "done in reset");
        areset_cu_setup = 1'b0;
        check_flag(descriptor_ready, 1'b0, "descriptor_ready in SETUP_RESET");

        wait_cycles = 0;
        while (!descriptor_ready && wait_cycles < 8) begin
            @(negedge ap_clk);
            wait_cycles++;
        end
        if (!descriptor_ready) begin
            errors++;
            $display("ERROR: descriptor_ready did not rise after reset");
        end
        check_flag(request_valid, 1'b0, "request_valid after reset");
        check_flag(done, 1'b0, "done after reset");

        for (run = 0; run < NUM_RUNS; run++) begin
            rng_stim = xorshift32(rng_stim);
            if (run == 1 || run == 9) begin
                count = '0;
            end else if (run == 2) begin
                count = count_t'(MAX_COUNT);
            end else begin
                count = count_t'(rng_stim % 32'(MAX_COUNT + 1));
            end
            rng_stim = xorshift32(rng_stim);
            base = rng_stim;
            stall_heavy = (run % 3 == 2);
            // Odd runs go back to back while done is still high
            if (run % 2 == 0) begin
                rng_stim = xorshift32(rng_stim);
                gap = int'(rng_stim[2:0]);
                repeat (gap) @(negedge ap_clk);
            end
            send_descriptor(base, count);
            wait_done();
        end

        @(negedge ap_clk);
        check_count(count_t'(runs_checked), count_t'(NUM_RUNS), "runs completed");
        $display("Simulation finished with %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: timeout, the runs did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: cu_setup.f
common/cu_setup_pkg.sv
hw/setup_input_regs.sv
hw/setup/setup_sequencer.sv
hw/setup/serial_read_engine.sv
hw/request_fifo.sv
hw/cu_setup_top.sv
verif/tb_cu_setup.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cu_setup \
    -f cu_setup.f -o sim_cu_setup \
    && ./obj_dir/sim_cu_setup 2>&1 | tee sim.log \
    || { echo "Simulation did not build or run to completion"; exit 1; }
grep -q "Test failures found" sim.log \
    && { echo "RESULT: FAIL"; exit 1; } \
    || { echo "RESULT: PASS"; exit 0; }
